// ==== hw/ntt_consts.svh ====
`ifndef NTT_CONSTS_SVH
`define NTT_CONSTS_SVH

// ML-DSA prime modulus, q = 2^23 - 2^13 + 1
`define NTT_Q 23'd8380417

// Coefficient width in bits
`define NTT_WIDTH 23

// Modular multiplier depth in clock cycles
`define MULT_LAT 3

// Butterfly depth in clock cycles, the same for every mode
`define BF_LAT 4

`endif

// ==== hw/ntt_ctrl_pkg.sv ====
`default_nettype none

package ntt_ctrl_pkg;

    // Operation modes
    // ct and gs run two butterfly layers, the pw modes run four lanes
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_t;

    // Control that moves down the pipeline next to its data
    typedef struct packed {
        logic  valid;
        mode_t mode;
    } ntt_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/ntt_data_pkg.sv ====
`default_nettype none
`include "ntt_consts.svh"

package ntt_data_pkg;

    // Butterfly operands, two layer-1 pairs and four twiddles
    typedef struct packed {
        logic [`NTT_WIDTH-1:0] u00;
        logic [`NTT_WIDTH-1:0] u01;
        logic [`NTT_WIDTH-1:0] v00;
        logic [`NTT_WIDTH-1:0] v01;
        logic [`NTT_WIDTH-1:0] w00;
        logic [`NTT_WIDTH-1:0] w01;
        logic [`NTT_WIDTH-1:0] w10;
        logic [`NTT_WIDTH-1:0] w11;
    } bf_uvw_t;

    // Pointwise operands, one u/v pair per lane
    typedef struct packed {
        logic [`NTT_WIDTH-1:0] u0;
        logic [`NTT_WIDTH-1:0] u1;
        logic [`NTT_WIDTH-1:0] u2;
        logic [`NTT_WIDTH-1:0] u3;
        logic [`NTT_WIDTH-1:0] v0;
        logic [`NTT_WIDTH-1:0] v1;
        logic [`NTT_WIDTH-1:0] v2;
        logic [`NTT_WIDTH-1:0] v3;
    } pw_uvw_t;

    // Layer-2 butterfly results
    typedef struct packed {
        logic [`NTT_WIDTH-1:0] u20;
        logic [`NTT_WIDTH-1:0] u21;
        logic [`NTT_WIDTH-1:0] v20;
        logic [`NTT_WIDTH-1:0] v21;
    } bf_uvo_t;

    // Pointwise results, lane 0 to lane 3
    typedef struct packed {
        logic [`NTT_WIDTH-1:0] uv0;
        logic [`NTT_WIDTH-1:0] uv1;
        logic [`NTT_WIDTH-1:0] uv2;
        logic [`NTT_WIDTH-1:0] uv3;
    } pwo_t;

    // Operand triple for a single butterfly unit
    typedef struct packed {
        logic [`NTT_WIDTH-1:0] u;
        logic [`NTT_WIDTH-1:0] v;
        logic [`NTT_WIDTH-1:0] w;
    } bf_op_t;

endpackage

`default_nettype wire

// ==== hw/ntt_mod_mult.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ntt_consts.svh"

module ntt_mod_mult (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic [`NTT_WIDTH-1:0] a_i,
    input  logic [`NTT_WIDTH-1:0] b_i,
    output logic [`NTT_WIDTH-1:0] p_o
);

    logic [2*`NTT_WIDTH-1:0] prod_q;
    logic [36:0]             fold1;
    logic [27:0]             fold2;
    logic [27:0]             fold2_q;
    logic [`NTT_WIDTH:0]     fold3;
    logic [`NTT_WIDTH:0]     fold3_sub;

    // 2^23 mod q is 2^13 - 1, so each fold maps h*2^23 + l to (h << 13) - h + l
    assign fold1 = ({14'd0, prod_q[45:23]} << 13) - {14'd0, prod_q[45:23]}
                 + {14'd0, prod_q[22:0]};
    assign fold2 = ({14'd0, fold1[36:23]} << 13) - {14'd0, fold1[36:23]}
                 + {5'd0, fold1[22:0]};

    // Third fold leaves a value below 2q
    assign fold3 = ({19'd0, fold2_q[27:23]} << 13) - {19'd0, fold2_q[27:23]}
                 + {1'b0, fold2_q[22:0]};
    assign fold3_sub = fold3 - {1'b0, `NTT_Q};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q  <= '0;
            fold2_q <= '0;
            p_o     <= '0;
        end else if (zeroize_i) begin
            prod_q  <= '0;
            fold2_q <= '0;
            p_o     <= '0;
        end else begin
            prod_q  <= a_i * b_i;
            fold2_q <= fold2;
            p_o     <= fold3_sub[`NTT_WIDTH] ? fold3[`NTT_WIDTH-1:0]
                                             : fold3_sub[`NTT_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/ntt_butterfly.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ntt_consts.svh"

module ntt_butterfly
    import ntt_ctrl_pkg::*;
    import ntt_data_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  ntt_ctrl_t             ctrl_i,
    input  bf_op_t                op_i,
    output ntt_ctrl_t             ctrl_o,
    output logic [`NTT_WIDTH-1:0] u_o,
    output logic [`NTT_WIDTH-1:0] v_o
);

    function automatic logic [`NTT_WIDTH-1:0] mod_add(input logic [`NTT_WIDTH-1:0] a,
                                                       input logic [`NTT_WIDTH-1:0] b);
        logic [`NTT_WIDTH:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, `NTT_Q}) begin
            s = s - {1'b0, `NTT_Q};
        end
        return s[`NTT_WIDTH-1:0];
    endfunction

    function automatic logic [`NTT_WIDTH-1:0] mod_sub(input logic [`NTT_WIDTH-1:0] a,
                                                       input logic [`NTT_WIDTH-1:0] b);
        logic [`NTT_WIDTH:0] d;
        d = {1'b0, a} - {1'b0, b};
        // Borrow out means a < b, add q back
        if (d[`NTT_WIDTH]) begin
            d = d + {1'b0, `NTT_Q};
        end
        return d[`NTT_WIDTH-1:0];
    endfunction

    logic [`NTT_WIDTH-1:0]                sum, diff;
    logic [`NTT_WIDTH-1:0]                mul_a, mul_b, mul_p;
    logic [`NTT_WIDTH-1:0]                pre_d;
    logic [`MULT_LAT-1:0][`NTT_WIDTH-1:0] d_q;
    ntt_ctrl_t [`BF_LAT-1:0]              ctrl_q;
    mode_t                                post_mode;

    // --------------------------------------------------
    // Pre-adder and multiplier steering
    // --------------------------------------------------
    assign sum  = mod_add(op_i.u, op_i.v);
    assign diff = mod_sub(op_i.u, op_i.v);

    always_comb begin
        mul_a = '0;
        mul_b = '0;
        pre_d = '0;
        case (ctrl_i.mode)
            ct:  begin mul_a = op_i.v;  mul_b = op_i.w; pre_d = op_i.u; end
            gs:  begin mul_a = diff;    mul_b = op_i.w; pre_d = sum;    end
            pwm: begin mul_a = op_i.u;  mul_b = op_i.v;                 end
            pwa: pre_d = sum;
            pws: pre_d = diff;
            default: pre_d = '0;
        endcase
    end

    ntt_mod_mult mult_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .p_o       (mul_p)
    );

    // --------------------------------------------------
    // Delay lines and post-adder
    // --------------------------------------------------
    // Mode of the operation now leaving the multiplier
    assign post_mode = ctrl_q[`MULT_LAT-1].mode;
    assign ctrl_o    = ctrl_q[`BF_LAT-1];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            d_q    <= '0;
            ctrl_q <= '0;
            u_o    <= '0;
            v_o    <= '0;
        end else if (zeroize_i) begin
            d_q    <= '0;
            ctrl_q <= '0;
            u_o    <= '0;
            v_o    <= '0;
        end else begin
            d_q    <= {d_q[`MULT_LAT-2:0], pre_d};
            ctrl_q <= {ctrl_q[`BF_LAT-2:0], ctrl_i};
            case (post_mode)
                ct: begin
                    u_o <= mod_add(d_q[`MULT_LAT-1], mul_p);
                    v_o <= mod_sub(d_q[`MULT_LAT-1], mul_p);
                end
                gs: begin
                    u_o <= d_q[`MULT_LAT-1];
                    v_o <= mul_p;
                end
                pwm: begin
                    u_o <= mul_p;
                    v_o <= '0;
                end
                default: begin
                    u_o <= d_q[`MULT_LAT-1];
                    v_o <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/ntt_operand_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module ntt_operand_select
    import ntt_ctrl_pkg::*;
    import ntt_data_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      zeroize_i,
    input  logic      enable_i,
    input  mode_t     mode_i,
    input  bf_uvw_t   uvw_i,
    input  pw_uvw_t   pw_uvw_i,
    output ntt_ctrl_t ctrl_o,
    output bf_uvw_t   bf_o,
    output pw_uvw_t   pw_o
);

    logic pw_sel;

    assign pw_sel = mode_i inside {pwm, pwa, pws};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_o <= '0;
            bf_o   <= '0;
            pw_o   <= '0;
        end else if (zeroize_i) begin
            ctrl_o <= '0;
            bf_o   <= '0;
            pw_o   <= '0;
        end else begin
            ctrl_o.valid <= enable_i;
            // Mode is held between operations so idle cycles keep the last steering
            if (enable_i) begin
                ctrl_o.mode <= mode_i;
            end
            // Only the set for the active mode is loaded, the other one stays at zero
            bf_o <= (enable_i && !pw_sel) ? uvw_i : '0;
            pw_o <= (enable_i && pw_sel) ? pw_uvw_i : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ntt_hybrid_butterfly_2x2.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ntt_consts.svh"

module ntt_hybrid_butterfly_2x2
    import ntt_ctrl_pkg::*;
    import ntt_data_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      zeroize_i,
    input  ntt_ctrl_t ctrl_i,
    input  bf_uvw_t   bf_i,
    input  pw_uvw_t   pw_i,
    output bf_uvo_t   uv_o,
    output pwo_t      pwo_o,
    output logic      ready_o
);

    logic [`BF_LAT-1:0][`NTT_WIDTH-1:0] w10_q, w11_q;
    logic [`NTT_WIDTH-1:0]              a0, a1, b0, b1;
    ntt_ctrl_t                          ctrl_a, ctrl_c, ctrl_l2;
    bf_op_t                             op_a, op_b, op_c, op_d;
    logic                               in_pw, l1_bf;

    // Twiddles for layer 2 wait for the layer-1 results
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_q <= '0;
            w11_q <= '0;
        end else if (zeroize_i) begin
            w10_q <= '0;
            w11_q <= '0;
        end else begin
            w10_q <= {w10_q[`BF_LAT-2:0], bf_i.w10};
            w11_q <= {w11_q[`BF_LAT-2:0], bf_i.w11};
        end
    end

    // --------------------------------------------------
    // Operand steering for both layers
    // --------------------------------------------------
    assign in_pw = ctrl_i.mode inside {pwm, pwa, pws};
    assign l1_bf = ctrl_a.valid && (ctrl_a.mode inside {ct, gs});

    always_comb begin
        op_a = in_pw ? {pw_i.u0, pw_i.v0, {`NTT_WIDTH{1'b0}}} : {bf_i.u00, bf_i.v00, bf_i.w00};
        op_b = in_pw ? {pw_i.u1, pw_i.v1, {`NTT_WIDTH{1'b0}}} : {bf_i.u01, bf_i.v01, bf_i.w01};
        if (l1_bf) begin
            // Layer 2 of a ct or gs operation
            ctrl_l2 = ctrl_a;
            op_c    = {a0, b0, w10_q[`BF_LAT-1]};
            op_d    = {a1, b1, w11_q[`BF_LAT-1]};
        end else begin
            // Pointwise lanes 2 and 3 enter directly
            ctrl_l2       = ctrl_i;
            ctrl_l2.valid = ctrl_i.valid && in_pw;
            op_c          = {pw_i.u2, pw_i.v2, {`NTT_WIDTH{1'b0}}};
            op_d          = {pw_i.u3, pw_i.v3, {`NTT_WIDTH{1'b0}}};
        end
    end

    ntt_butterfly bf_a (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .ctrl_i(ctrl_i), .op_i(op_a), .ctrl_o(ctrl_a), .u_o(a0), .v_o(a1)
    );

    ntt_butterfly bf_b (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .ctrl_i(ctrl_i), .op_i(op_b), .ctrl_o(), .u_o(b0), .v_o(b1)
    );

    ntt_butterfly bf_c (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .ctrl_i(ctrl_l2), .op_i(op_c), .ctrl_o(ctrl_c), .u_o(uv_o.u20), .v_o(uv_o.v20)
    );

    ntt_butterfly bf_d (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .ctrl_i(ctrl_l2), .op_i(op_d), .ctrl_o(), .u_o(uv_o.u21), .v_o(uv_o.v21)
    );

    // Pointwise results sit on the u outputs
    assign pwo_o = {a0, b0, uv_o.u20, uv_o.u21};

    assign ready_o = (ctrl_c.valid && (ctrl_c.mode inside {ct, gs})) ||
                     (ctrl_a.valid && (ctrl_a.mode inside {pwm, pwa, pws}));

endmodule

`default_nettype wire

// ==== hw/ntt_bf_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ntt_bf_top
    import ntt_ctrl_pkg::*;
    import ntt_data_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    zeroize_i,
    input  logic    enable_i,
    input  mode_t   mode_i,
    input  bf_uvw_t uvw_i,
    input  pw_uvw_t pw_uvw_i,
    output bf_uvo_t uv_o,
    output pwo_t    pwo_o,
    output logic    ready_o
);

    ntt_ctrl_t ctrl;
    bf_uvw_t   bf_ops;
    pw_uvw_t   pw_ops;

    // Input register stage
    ntt_operand_select operand_select_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .enable_i(enable_i), .mode_i(mode_i), .uvw_i(uvw_i), .pw_uvw_i(pw_uvw_i),
        .ctrl_o(ctrl), .bf_o(bf_ops), .pw_o(pw_ops)
    );

    // Two butterfly layers
    ntt_hybrid_butterfly_2x2 butterfly_2x2_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .ctrl_i(ctrl), .bf_i(bf_ops), .pw_i(pw_ops),
        .uv_o(uv_o), .pwo_o(pwo_o), .ready_o(ready_o)
    );

endmodule

`default_nettype wire

// ==== bench/ntt_bf_properties.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ntt_consts.svh"

module ntt_bf_properties
    import ntt_ctrl_pkg::*;
    import ntt_data_pkg::*;
(
    input logic    clk,
    input logic    reset_n,
    input logic    enable_i,
    input mode_t   mode_i,
    input logic    ready_o,
    input bf_uvo_t uv_o,
    input pwo_t    pwo_o
);

    // Failure counts, read by the testbench at the end of the run
    int rst_fails = 0;
    int mode_fails = 0;
    int range_fails = 0;

    a_no_ready_in_reset: assert property (@(posedge clk) !reset_n |-> !ready_o)
        else begin
            $error("ready_o high while reset_n is low");
            rst_fails++;
        end

    a_mode_known: assert property (@(posedge clk) disable iff (!reset_n)
        enable_i |-> !$isunknown(mode_i))
        else begin
            $error("mode_i has unknown bits while enable_i is high");
            mode_fails++;
        end

    // Every result field is fully reduced
    a_results_below_q: assert property (@(posedge clk) disable iff (!reset_n)
        ready_o |-> (uv_o.u20 < `NTT_Q) && (uv_o.u21 < `NTT_Q) && (uv_o.v20 < `NTT_Q)
                 && (uv_o.v21 < `NTT_Q) && (pwo_o.uv0 < `NTT_Q) && (pwo_o.uv1 < `NTT_Q)
                 && (pwo_o.uv2 < `NTT_Q) && (pwo_o.uv3 < `NTT_Q))
        else begin
            $error("result field not below q while ready_o is high");
            range_fails++;
        end

endmodule

bind ntt_bf_top ntt_bf_properties properties_inst (
    .clk(clk), .reset_n(reset_n), .enable_i(enable_i), .mode_i(mode_i),
    .ready_o(ready_o), .uv_o(uv_o), .pwo_o(pwo_o)
);

`default_nettype wire

// ==== bench/ntt_bf_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ntt_consts.svh"

module ntt_bf_tb
    import ntt_ctrl_pkg::*;
    import ntt_data_pkg::*;
;

    typedef logic [`NTT_WIDTH-1:0] coef_t;

    // Expected result, tagged with its mode and the edge where enable was sampled
    typedef struct packed {
        mode_t   mode;
        int      issue;
        bf_uvo_t bf;
        pwo_t    pw;
    } exp_t;

    localparam logic [63:0] Q64 = 64'(`NTT_Q);
    localparam int DRAIN_LIMIT = 4 * `BF_LAT + 4;
    localparam int STIM_CYCLES = 10 + 50 + 50 * 4 + 3 * 30 + 5 * 9 + 6 + 2 * `BF_LAT + 12;
    localparam int DRAIN_COUNT = 12;
    localparam int TIMEOUT_CYCLES = 2 * (STIM_CYCLES + DRAIN_COUNT * 2 * `BF_LAT);

    logic    clk;
    logic    reset_n;
    logic    zeroize_i;
    logic    enable_i;
    mode_t   mode_i;
    bf_uvw_t uvw_i;
    pw_uvw_t pw_uvw_i;
    bf_uvo_t uv_o;
    pwo_t    pwo_o;
    logic    ready_o;

    integer seed = 32'h01678072;
    int     cycle = 0;
    int     issued = 0;
    int     readies = 0;
    int     checks = 0;
    int     cmp_errors = 0;
    int     seq_errors = 0;
    exp_t   exp_q[$];

    ntt_bf_top ntt_bf_top_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .enable_i(enable_i),
        .mode_i(mode_i), .uvw_i(uvw_i), .pw_uvw_i(pw_uvw_i),
        .uv_o(uv_o), .pwo_o(pwo_o), .ready_o(ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Edge counter and watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Reference model, arithmetic mod q
    // --------------------------------------------------
    function automatic coef_t q_add(input coef_t a, input coef_t b);
        return coef_t'((64'(a) + 64'(b)) % Q64);
    endfunction

    function automatic coef_t q_sub(input coef_t a, input coef_t b);
        return coef_t'((64'(a) + Q64 - 64'(b)) % Q64);
    endfunction

    function automatic coef_t q_mul(input coef_t a, input coef_t b);
        return coef_t'((64'(a) * 64'(b)) % Q64);
    endfunction

    function automatic void bfly(input mode_t m, input coef_t u, input coef_t v,
                                 input coef_t w, output coef_t hi, output coef_t lo);
        if (m == ct) begin
            hi = q_add(u, q_mul(w, v));
            lo = q_sub(u, q_mul(w, v));
        end else begin
            hi = q_add(u, v);
            lo = q_mul(q_sub(u, v), w);
        end
    endfunction

    function automatic bf_uvo_t ref_bf(input mode_t m, input bf_uvw_t x);
        bf_uvo_t r;
        coef_t   a0, a1, b0, b1;
        bfly(m, x.u00, x.v00, x.w00, a0, a1);
        bfly(m, x.u01, x.v01, x.w01, b0, b1);
        bfly(m, a0, b0, x.w10, r.u20, r.v20);
        bfly(m, a1, b1, x.w11, r.u21, r.v21);
        return r;
    endfunction

    function automatic coef_t lane(input mode_t m, input coef_t u, input coef_t v);
        case (m)
            pwm:     return q_mul(u, v);
            pwa:     return q_add(u, v);
            default: return q_sub(u, v);
        endcase
    endfunction

    function automatic pwo_t ref_pw(input mode_t m, input pw_uvw_t x);
        pwo_t r;
        r.uv0 = lane(m, x.u0, x.v0);
        r.uv1 = lane(m, x.u1, x.v1);
        r.uv2 = lane(m, x.u2, x.v2);
        r.uv3 = lane(m, x.u3, x.v3);
        return r;
    endfunction

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic coef_t rand_coef();
        logic [31:0] r;
        r = $random(seed);
        return coef_t'(64'(r) % Q64);
    endfunction

    // Eight random coefficients, fits either operand struct
    function automatic logic [8*`NTT_WIDTH-1:0] rand_set();
        logic [8*`NTT_WIDTH-1:0] bits;
        bits = '0;
        for (int i = 0; i < 8; i++) begin
            bits = {bits[7*`NTT_WIDTH-1:0], rand_coef()};
        end
        return bits;
    endfunction

    function automatic coef_t edge_value(input int i);
        case (i % 3)
            0:       return '0;
            1:       return coef_t'(1);
            default: return `NTT_Q - 23'd1;
        endcase
    endfunction

    function automatic int error_total();
        return cmp_errors + seq_errors;
    endfunction

    task automatic issue_op(input mode_t m, input bf_uvw_t bf, input pw_uvw_t pw,
                            input bit keep);
        exp_t e;
        @(posedge clk);
        enable_i <= 1'b1;
        mode_i   <= m;
        uvw_i    <= bf;
        pw_uvw_i <= pw;
        if (keep) begin
            e = '0;
            e.mode = m;
            // Enable is sampled on the edge after this one
            e.issue = cycle + 2;
            if (m inside {ct, gs}) begin
                e.bf = ref_bf(m, bf);
            end else begin
                e.pw = ref_pw(m, pw);
            end
            exp_q.push_back(e);
            issued++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            enable_i <= 1'b0;
        end
    endtask

    // Waits for every pending result, then holds the gap for a group switch
    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        repeat (2 * `BF_LAT) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("Missing ready_o: %0d results never arrived", exp_q.size());
            seq_errors += exp_q.size();
            exp_q.delete();
        end
        if (readies != issued) begin
            $display("Ready count %0d does not match %0d issued operations", readies, issued);
            seq_errors++;
        end
    endtask

    task automatic run_pw_batch(input mode_t m, input int n);
        for (int i = 0; i < n; i++) begin
            issue_op(m, '0, rand_set(), 1'b1);
        end
        drain();
    endtask

    // All pairs of 0, 1 and q-1, twiddles cycling through the same values
    task automatic run_edges(input mode_t m);
        bf_uvw_t x;
        pw_uvw_t p;
        coef_t   u, v, w;
        for (int i = 0; i < 9; i++) begin
            u = edge_value(i / 3);
            v = edge_value(i);
            w = edge_value(i + 1 + i / 3);
            x = {u, v, v, u, w, v, u, w};
            p = {u, v, u, w, v, u, w, v};
            issue_op(m, x, p, 1'b1);
        end
        drain();
    endtask

    task automatic report_test(input string name, input int ops, input int base);
        $display("Test %-26s %3d ops, %0d errors", name, ops, error_total() - base);
    endtask

    // --------------------------------------------------
    // Compare process
    // --------------------------------------------------
    task automatic compare_coef(input string name, input coef_t exp_v, input coef_t act_v);
        if (exp_v !== act_v) begin
            $display("ERROR %s expected 0x%06h actual 0x%06h", name, exp_v, act_v);
            cmp_errors++;
        end
    endtask

    task automatic check_bf(input bf_uvo_t exp_v, input bf_uvo_t act_v);
        compare_coef("uv_o.u20", exp_v.u20, act_v.u20);
        compare_coef("uv_o.u21", exp_v.u21, act_v.u21);
        compare_coef("uv_o.v20", exp_v.v20, act_v.v20);
        compare_coef("uv_o.v21", exp_v.v21, act_v.v21);
    endtask

    task automatic check_pw(input pwo_t exp_v, input pwo_t act_v);
        compare_coef("pwo_o.uv0", exp_v.uv0, act_v.uv0);
        compare_coef("pwo_o.uv1", exp_v.uv1, act_v.uv1);
        compare_coef("pwo_o.uv2", exp_v.uv2, act_v.uv2);
        compare_coef("pwo_o.uv3", exp_v.uv3, act_v.uv3);
    endtask

    initial begin : compare_results
        exp_t e;
        int   lat;
        forever begin
            @(posedge clk);
            if (reset_n && ready_o) begin
                readies++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected ready_o at edge %0d with no operation pending", cycle);
                    cmp_errors++;
                end else begin
                    e = exp_q.pop_front();
                    lat = (e.mode inside {ct, gs}) ? 2 * `BF_LAT : `BF_LAT;
                    if (cycle - e.issue != lat) begin
                        $display("Operation sampled at edge %0d was ready after %0d edges, not %0d",
                                 e.issue, cycle - e.issue, lat);
                        cmp_errors++;
                    end
                    if (e.mode inside {ct, gs}) begin
                        check_bf(e.bf, uv_o);
                    end else begin
                        check_pw(e.pw, pwo_o);
                    end
                    checks++;
                end
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : run_tests
        int base;
        int gap;
        int fails;
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        enable_i  = 1'b0;
        mode_i    = ct;
        uvw_i     = '0;
        pw_uvw_i  = '0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        idle(2);

        base = error_total();
        for (int i = 0; i < 50; i++) begin
            issue_op(ct, rand_set(), '0, 1'b1);
        end
        drain();
        report_test("ct back to back", 50, base);

        base = error_total();
        for (int i = 0; i < 50; i++) begin
            issue_op(gs, rand_set(), '0, 1'b1);
            gap = int'(rand_coef()) % 4;
            idle(gap);
        end
        drain();
        report_test("gs with random gaps", 50, base);

        base = error_total();
        run_pw_batch(pwm, 30);
        run_pw_batch(pwa, 30);
        run_pw_batch(pws, 30);
        report_test("pointwise pwm pwa pws", 90, base);

        base = error_total();
        run_edges(ct);
        run_edges(gs);
        run_edges(pwm);
        run_edges(pwa);
        run_edges(pws);
        report_test("boundary operands", 45, base);

        // Six ct operations in flight, none may finish
        base = error_total();
        for (int i = 0; i < 6; i++) begin
            issue_op(ct, rand_set(), '0, 1'b0);
        end
        @(posedge clk);
        enable_i  <= 1'b0;
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        repeat (2 * `BF_LAT + 2) @(posedge clk);
        for (int i = 0; i < 10; i++) begin
            issue_op(ct, rand_set(), '0, 1'b1);
        end
        drain();
        report_test("zeroize during ct", 16, base);

        fails = ntt_bf_top_inst.properties_inst.rst_fails
              + ntt_bf_top_inst.properties_inst.mode_fails
              + ntt_bf_top_inst.properties_inst.range_fails;
        $display("Results checked %0d, errors %0d, assertion failures %0d",
                 checks, error_total(), fails);
        if (error_total() == 0 && fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/ntt_ctrl_pkg.sv
hw/ntt_data_pkg.sv
hw/ntt_mod_mult.sv
hw/ntt_butterfly.sv
hw/ntt_operand_select.sv
hw/ntt_hybrid_butterfly_2x2.sv
hw/ntt_bf_top.sv
bench/ntt_bf_properties.sv
bench/ntt_bf_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = ntt_bf_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
